// File: vlog.f
+incdir+logic
logic/ex_pkg.sv
logic/stage_if.sv
logic/issue_stage.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/ex_pipe_top.sv
tb/ex_pipe_chk.sv
tb/ex_pipe_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ex_pipe_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard logic/*.sv logic/*.svh tb/*.sv) $(FILELIST)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/ex_pipe_tb.sv
// execute slice testbench
`timescale 1ns/1ps

module ex_pipe_tb;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] in_uop;
  logic        in_allowin;
  logic        result_ready;
  logic        result_valid;
  logic [4:0]  result_rd;
  logic [63:0] result_data;

  // model state and scoreboard
  logic [63:0] mrf [32];
  logic [4:0]  exp_rd_q [$];
  logic [63:0] exp_data_q [$];
  int          exp_cyc_q [$];
  int          cyc;
  int          errors;
  int          checked;
  logic        stall_mode;
  logic        check_lat;
  logic [31:0] stim_lfsr;
  logic [31:0] rdy_lfsr;

  ex_pipe_top DUT (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_uop       (in_uop),
    .in_allowin   (in_allowin),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // cycle count for latency
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] stim_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] ready_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      rdy_lfsr = lfsr_next(rdy_lfsr);
      v = {v[30:0], rdy_lfsr[0]};
    end
    return v;
  endfunction

  // expected alu result from the opcode rules
  function automatic logic [63:0] ref_alu(input logic [3:0] op, input logic word,
                                          input logic [63:0] a, input logic [63:0] b);
    logic [63:0]        r;
    logic [31:0]        w;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a[31:0];
    sb = b[31:0];
    if (word) begin
      case (op)
        4'd1: w = a[31:0] - b[31:0];
        4'd2: w = a[31:0] & b[31:0];
        4'd3: w = a[31:0] | b[31:0];
        4'd4: w = a[31:0] ^ b[31:0];
        4'd5: w = a[31:0] << b[4:0];
        4'd6: w = a[31:0] >> b[4:0];
        4'd7: w = sa >>> b[4:0];
        4'd8: w = {31'd0, sa < sb};
        4'd9: w = {31'd0, a[31:0] < b[31:0]};
        default: w = a[31:0] + b[31:0];
      endcase
      r = {{32{w[31]}}, w};
    end else begin
      case (op)
        4'd1: r = a - b;
        4'd2: r = a & b;
        4'd3: r = a | b;
        4'd4: r = a ^ b;
        4'd5: r = a << b[5:0];
        4'd6: r = a >> b[5:0];
        4'd7: r = $signed(a) >>> b[5:0];
        4'd8: r = {63'd0, $signed(a) < $signed(b)};
        4'd9: r = {63'd0, a < b};
        default: r = a + b;
      endcase
    end
    return r;
  endfunction

  function automatic logic [31:0] make_uop(input logic [3:0] op, input logic word,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic use_imm, input logic [15:0] src2);
    return {op, word, rd, rs1, use_imm, src2};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d, results checked: %0d, left over: %0d",
             errors, checked, exp_rd_q.size());
    if (errors == 0 && exp_rd_q.size() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // accepted ops go through the model in order
  always @(negedge clk) begin
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    if (!rst && in_valid && in_allowin) begin
      a = mrf[in_uop[21:17]];
      b = in_uop[16] ? {{48{in_uop[15]}}, in_uop[15:0]} : mrf[in_uop[4:0]];
      r = ref_alu(in_uop[31:28], in_uop[27], a, b);
      if (in_uop[26:22] != 5'd0) begin
        mrf[in_uop[26:22]] = r;
      end
      exp_rd_q.push_back(in_uop[26:22]);
      exp_data_q.push_back(r);
      exp_cyc_q.push_back(cyc);
    end
  end

  // compare each taken result with the oldest expected one
  always @(negedge clk) begin
    if (!rst && result_valid && result_ready) begin
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("result taken at %0t with nothing expected", $time);
      end else begin
        check_val("result_rd", 64'(result_rd), 64'(exp_rd_q.pop_front()));
        check_val("result_data", result_data, exp_data_q.pop_front());
        if (check_lat) begin
          check_val("latency", 64'(cyc - exp_cyc_q[0]), 64'd3);
        end
        void'(exp_cyc_q.pop_front());
        checked++;
      end
    end
  end

  always @(posedge clk) begin
    if (stall_mode) begin
      result_ready <= |ready_bits(2);
    end else begin
      result_ready <= 1'b1;
    end
  end

  task automatic send(input logic [31:0] u);
    int t;
    @(posedge clk);
    in_valid <= 1'b1;
    in_uop   <= u;
    t = 0;
    @(negedge clk);
    // continuous flow takes one op every cycle
    if (check_lat && !in_allowin) begin
      errors++;
      $display("input held off during continuous flow at %0t", $time);
    end
    while (!in_allowin && t < 100) begin
      t++;
      @(negedge clk);
    end
    if (!in_allowin) begin
      errors++;
      $display("timeout: micro-op never accepted");
      finish_run();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    int t;
    idle(1);
    t = 0;
    while (exp_rd_q.size() != 0 && t < 500) begin
      t++;
      @(negedge clk);
    end
    if (exp_rd_q.size() != 0) begin
      errors++;
      $display("timeout: results still missing after input stopped");
      finish_run();
    end
  endtask

  initial begin
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_uop       = '0;
    result_ready = 1'b0;
    stall_mode   = 1'b0;
    check_lat    = 1'b0;
    stim_lfsr    = 32'hac59_1bce;
    rdy_lfsr     = 32'hac59_1bce;
    cyc          = 0;
    errors       = 0;
    checked      = 0;
    for (int i = 0; i < 32; i++) begin
      mrf[i] = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // immediate loads, then read back
    for (int r = 1; r < 32; r++) begin
      send(make_uop(4'd0, 1'b0, r[4:0], 5'd0, 1'b1, 16'(stim_bits(16))));
    end
    for (int r = 1; r < 32; r++) begin
      send(make_uop(4'd3, 1'b0, r[4:0], r[4:0], 1'b1, 16'd0));
    end
    // x0 writes are dropped
    send(make_uop(4'd0, 1'b0, 5'd0, 5'd7, 1'b1, 16'h1234));
    send(make_uop(4'd0, 1'b0, 5'd9, 5'd0, 1'b0, 16'd0));
    drain();

    // every opcode, full and word, with gaps and stalls
    stall_mode <= 1'b1;
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 12; k++) begin
        if (stim_bits(2) == 0) begin
          idle(stim_bits(2) + 1);
        end
        send(make_uop(op[3:0], k[0], 5'(stim_bits(5)), 5'(stim_bits(5)),
                      1'(stim_bits(1)), 16'(stim_bits(16))));
      end
    end
    drain();

    // dependent chain with no gaps
    stall_mode <= 1'b0;
    for (int k = 0; k < 40; k++) begin
      send(make_uop(4'(stim_bits(4)), 1'(stim_bits(1)), 5'd11, 5'd11, 1'(stim_bits(1)),
                    {11'd0, 5'd11}));
    end
    drain();

    // long random run under stalls
    stall_mode <= 1'b1;
    for (int k = 0; k < 300; k++) begin
      if (stim_bits(3) == 0) begin
        idle(1);
      end
      send(stim_bits(32));
    end
    drain();

    // fixed latency with continuous flow
    stall_mode <= 1'b0;
    idle(2);
    check_lat = 1'b1;
    for (int k = 0; k < 50; k++) begin
      send(stim_bits(32));
    end
    drain();
    check_lat = 1'b0;

    finish_run();
  end

endmodule

// File: tb/ex_pipe_chk.sv
// handshake assertions for the execute slice
`timescale 1ns/1ps

module ex_pipe_chk (
  input logic        clk,
  input logic        rst,
  input logic        in_valid,
  input logic        in_allowin,
  input logic        result_valid,
  input logic        result_ready,
  input logic [4:0]  result_rd,
  input logic [63:0] result_data
);

  // items between the input and result handshakes
  logic [2:0] in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 3'(in_valid && in_allowin) - 3'(result_valid && result_ready);
    end
  end

  // held result may not change until taken
  assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_ready |=> result_valid && $stable(result_rd)
                                      && $stable(result_data))
    else $error("result changed while stalled");

  assert property (@(posedge clk) $fell(rst) |-> !result_valid)
    else $error("result_valid high right after reset");

  // input stays open until all three stages hold an item
  assert property (@(posedge clk) disable iff (rst)
    in_flight < 3'd3 |-> in_allowin)
    else $error("in_allowin low with a free stage in the pipe");

endmodule

bind ex_pipe_top ex_pipe_chk u_chk (
  .clk          (clk),
  .rst          (rst),
  .in_valid     (in_valid),
  .in_allowin   (in_allowin),
  .result_valid (result_valid),
  .result_ready (result_ready),
  .result_rd    (result_rd),
  .result_data  (result_data)
);

// File: logic/ex_pipe_top.sv
// three-stage execute slice
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_pipe_top
  import ex_pkg::*;
(
  input  logic               clk,
  input  logic               rst,

  // micro-op input
  input  logic               in_valid,
  input  logic [`UOP_W-1:0]  in_uop,
  output logic               in_allowin,

  // result output
  input  logic               result_ready,
  output logic               result_valid,
  output logic [`REG_AW-1:0] result_rd,
  output logic [`XLEN_W-1:0] result_data
);

  // stage links
  stage_if #(.T(iss_t)) iss_link ();
  stage_if #(.T(res_t)) res_link ();
  reg_read_if           rd_port ();

  issue_stage u_issue (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_uop       (in_uop),
    .in_allowin   (in_allowin),
    .iss_link     (iss_link)
  );

  ex_stage u_ex (
    .clk          (clk),
    .rst          (rst),
    .iss_link     (iss_link),
    .res_link     (res_link),
    .rd_port      (rd_port)
  );

  wb_stage u_wb (
    .clk          (clk),
    .rst          (rst),
    .res_link     (res_link),
    .rd_port      (rd_port),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data)
  );

endmodule

// File: logic/wb_stage.sv
// writeback stage and register file
`timescale 1ns/1ps
`include "ex_config.svh"

module wb_stage
  import ex_pkg::*;
(
  input  logic               clk,
  input  logic               rst,

  // from execute
  stage_if.receiver          res_link,

  // operand reads for execute
  reg_read_if.responder      rd_port,

  // result output
  input  logic               result_ready,
  output logic               result_valid,
  output logic [`REG_AW-1:0] result_rd,
  output logic [`XLEN_W-1:0] result_data
);

  logic wb_valid;
  logic wb_allowin;
  logic wb_commit;
  res_t res_q;

  logic [`XLEN_W-1:0] rf [`NREG];

  // held result leaves when the consumer takes it
  assign wb_allowin       = !wb_valid || result_ready;
  assign res_link.allowin = wb_allowin;
  assign wb_commit        = wb_valid && result_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= res_link.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (res_link.valid && wb_allowin) begin
      res_q <= res_link.payload;
    end
  end

  // x0 stays zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREG; i++) begin
        rf[i] <= '0;
      end
    end else if (wb_commit && res_q.rd != '0) begin
      rf[res_q.rd] <= res_q.data;
    end
  end

  // x0, then the held result, then the file
  function automatic logic [`XLEN_W-1:0] read_reg(input logic [`REG_AW-1:0] addr);
    logic [`XLEN_W-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (wb_valid && res_q.rd == addr) begin
      val = res_q.data;
    end else begin
      val = rf[addr];
    end
    return val;
  endfunction

  always_comb begin
    rd_port.rs1_data = read_reg(rd_port.rs1_addr);
    rd_port.rs2_data = read_reg(rd_port.rs2_addr);
  end

  assign result_valid = wb_valid;
  assign result_rd    = res_q.rd;
  assign result_data  = res_q.data;

endmodule

// File: logic/ex_stage.sv
// integer execute stage
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic          clk,
  input  logic          rst,

  // from issue
  stage_if.receiver     iss_link,

  // to writeback
  stage_if.sender       res_link,

  // operand read, bypass included
  reg_read_if.requester rd_port
);

  logic ex_valid;
  logic ex_allowin;
  iss_t iss_q;

  // operands
  logic [`XLEN_W-1:0] op1;
  logic [`XLEN_W-1:0] op2;
  logic [`XLEN_W-1:0] op1_sext;
  logic [`XLEN_W-1:0] op2_sext;
  logic [`XLEN_W-1:0] op1_zext;
  logic [`XLEN_W-1:0] op2_zext;

  // alu internals
  logic [5:0]         shamt;
  logic [`XLEN_W-1:0] srl_src;
  logic [`XLEN_W-1:0] sra_src;
  logic               slt_res;
  logic               sltu_res;
  logic [`XLEN_W-1:0] alu_raw;
  logic [`XLEN_W-1:0] alu_out;
  res_t               res_bus;

  // result always ready, leaves as soon as writeback has room
  assign ex_allowin       = !ex_valid || res_link.allowin;
  assign iss_link.allowin = ex_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= iss_link.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_link.valid && ex_allowin) begin
      iss_q <= iss_link.payload;
    end
  end

  assign rd_port.rs1_addr = iss_q.rs1;
  assign rd_port.rs2_addr = iss_q.rs2;

  assign op1 = rd_port.rs1_data;
  assign op2 = iss_q.use_rs2 ? rd_port.rs2_data : iss_q.imm64;

  // low words widened for the word forms
  assign op1_sext = {{32{op1[31]}}, op1[31:0]};
  assign op2_sext = {{32{op2[31]}}, op2[31:0]};
  assign op1_zext = {32'd0, op1[31:0]};
  assign op2_zext = {32'd0, op2[31:0]};

  // word shifts use 5 bits of shift amount
  assign shamt   = iss_q.is_word ? {1'b0, op2[4:0]} : op2[5:0];
  assign srl_src = iss_q.is_word ? op1_zext : op1;
  assign sra_src = iss_q.is_word ? op1_sext : op1;

  assign slt_res  = iss_q.is_word ? ($signed(op1_sext) < $signed(op2_sext))
                                  : ($signed(op1) < $signed(op2));
  assign sltu_res = iss_q.is_word ? (op1_zext < op2_zext) : (op1 < op2);

  always_comb begin
    case (iss_q.op)
      ALU_SUB:  alu_raw = op1 - op2;
      ALU_AND:  alu_raw = op1 & op2;
      ALU_OR:   alu_raw = op1 | op2;
      ALU_XOR:  alu_raw = op1 ^ op2;
      ALU_SLL:  alu_raw = op1 << shamt;
      ALU_SRL:  alu_raw = srl_src >> shamt;
      ALU_SRA:  alu_raw = $signed(sra_src) >>> shamt;
      ALU_SLT:  alu_raw = {{(`XLEN_W-1){1'b0}}, slt_res};
      ALU_SLTU: alu_raw = {{(`XLEN_W-1){1'b0}}, sltu_res};
      // add and the spare codes
      default:  alu_raw = op1 + op2;
    endcase
  end

  // word results take the sign of bit 31
  assign alu_out = iss_q.is_word ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  assign res_bus.rd   = iss_q.rd;
  assign res_bus.data = alu_out;

  assign res_link.valid   = ex_valid;
  assign res_link.payload = res_bus;

endmodule

// File: logic/issue_stage.sv
// micro-op issue stage
`timescale 1ns/1ps
`include "ex_config.svh"

module issue_stage
  import ex_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // micro-op input
  input  logic     in_valid,
  input  uop_t     in_uop,
  output logic     in_allowin,

  // to execute
  stage_if.sender  iss_link
);

  logic is_valid;
  uop_t uop_q;

  // decoded second source
  logic               use_imm;
  logic [`REG_AW-1:0] src2_reg;
  logic [`XLEN_W-1:0] src2_imm;
  iss_t               iss_bus;

  // always ready to go, so space opens whenever execute takes the op
  assign in_allowin = !is_valid || iss_link.allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      is_valid <= 1'b0;
    end else if (in_allowin) begin
      is_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_allowin) begin
      uop_q <= in_uop;
    end
  end

  // one 16-bit field, two readings
  assign use_imm  = uop_q.use_imm;
  assign src2_reg = uop_q.src2.r.rs2;
  assign src2_imm = {{(`XLEN_W-`IMM_W){uop_q.src2.imm[`IMM_W-1]}}, uop_q.src2.imm};

  always_comb begin
    iss_bus.op      = uop_q.op;
    iss_bus.is_word = uop_q.is_word;
    iss_bus.rd      = uop_q.rd;
    iss_bus.rs1     = uop_q.rs1;
    iss_bus.use_rs2 = !use_imm;
    // unused view is zeroed so the read port sees x0
    if (use_imm) begin
      iss_bus.rs2   = '0;
      iss_bus.imm64 = src2_imm;
    end else begin
      iss_bus.rs2   = src2_reg;
      iss_bus.imm64 = '0;
    end
  end

  assign iss_link.valid   = is_valid;
  assign iss_link.payload = iss_bus;

endmodule

// File: logic/stage_if.sv
// pipeline link interfaces
`timescale 1ns/1ps
`include "ex_config.svh"

// valid/allowin link between two stages
interface stage_if #(
  parameter type T = logic
);
  logic valid;
  logic allowin;
  T     payload;

  modport sender (
    output valid,
    output payload,
    input  allowin
  );

  modport receiver (
    input  valid,
    input  payload,
    output allowin
  );
endinterface

// register read with bypass, answered combinationally
interface reg_read_if;
  logic [`REG_AW-1:0] rs1_addr;
  logic [`REG_AW-1:0] rs2_addr;
  logic [`XLEN_W-1:0] rs1_data;
  logic [`XLEN_W-1:0] rs2_data;

  modport requester (
    output rs1_addr,
    output rs2_addr,
    input  rs1_data,
    input  rs2_data
  );

  modport responder (
    input  rs1_addr,
    input  rs2_addr,
    output rs1_data,
    output rs2_data
  );
endinterface

// File: logic/ex_pkg.sv
// execute slice types
`include "ex_config.svh"

package ex_pkg;

  // alu opcodes, codes 10 to 15 fall back to add
  typedef enum logic [`OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // second source, register index or immediate depending on use_imm
  typedef union packed {
    struct packed {
      logic [`IMM_W-`REG_AW-1:0] unused;
      logic [`REG_AW-1:0]        rs2;
    } r;
    logic signed [`IMM_W-1:0] imm;
  } src2_u;

  // 32-bit micro-op word as seen at the top level
  typedef struct packed {
    alu_op_e            op;
    logic               is_word;
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic               use_imm;
    src2_u              src2;
  } uop_t;

  // issue to execute
  typedef struct packed {
    alu_op_e             op;
    logic                is_word;
    logic [`REG_AW-1:0]  rd;
    logic [`REG_AW-1:0]  rs1;
    logic                use_rs2;
    logic [`REG_AW-1:0]  rs2;
    logic [`XLEN_W-1:0]  imm64;
  } iss_t;

  // execute to writeback
  typedef struct packed {
    logic [`REG_AW-1:0] rd;
    logic [`XLEN_W-1:0] data;
  } res_t;

endpackage

// File: logic/ex_config.svh
// execute slice parameters
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath width
`define XLEN_W 64

// register file geometry
`define NREG   32
`define REG_AW 5

// micro-op fields
`define IMM_W  16
`define OP_W   4
`define UOP_W  32

`endif
